// File: design/streamParamsPkg.sv
package streamParamsPkg;

    // Ring of in-flight words
    // One trip around the ring is also the fixed input-to-output latency
    localparam int INDEX_WIDTH = 6;
    localparam int RING_LENGTH = 1 << INDEX_WIDTH;

    // Word geometry
    localparam int BOT_WIDTH = 128;
    localparam int CHUNK_WIDTH = 16;
    localparam int CHUNK_COUNT = BOT_WIDTH / CHUNK_WIDTH;

    // Shared input FIFO
    localparam int FIFO_DEPTH_LOG2 = 4;

    // Occupancy at which the source is asked to hold off
    localparam int SLOW_THRESHOLD = 8;

    // Tag entries per delay-memory word
    localparam int PACK_DEPTH_LOG2 = 4;

endpackage

// File: design/streamTypesPkg.sv
package streamTypesPkg;
    import streamParamsPkg::*;

    // A bot or top word
    // The flat view is used for masking, the chunk view for the scan
    typedef union packed {
        logic [BOT_WIDTH-1:0] flat;
        logic [CHUNK_COUNT-1:0][CHUNK_WIDTH-1:0] chunks;
    } botWordT;

    // Run count, wide enough for alternating bits over a full word
    typedef logic [INDEX_WIDTH:0] countT;

endpackage

// File: design/inputFifo.sv
module inputFifo
    import streamParamsPkg::*, streamTypesPkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     write,
    input  botWordT                  botIn,
    input  logic [INDEX_WIDTH-1:0]   indexIn,
    input  logic                     read,
    output botWordT                  dataOut,
    output logic [INDEX_WIDTH-1:0]   indexOut,
    output logic                     dataValid,
    output logic [FIFO_DEPTH_LOG2:0] used,
    output logic                     empty
);

    localparam int FIFO_DEPTH = 1 << FIFO_DEPTH_LOG2;

    botWordT botMem [FIFO_DEPTH];
    logic [INDEX_WIDTH-1:0] indexMem [FIFO_DEPTH];

    logic [FIFO_DEPTH_LOG2-1:0] writePtr;
    logic [FIFO_DEPTH_LOG2-1:0] readPtr;
    logic full;
    logic doWrite;
    logic doRead;

    assign empty = used == '0;
    assign full = used == (FIFO_DEPTH_LOG2 + 1)'(FIFO_DEPTH);

    // Writes into a full FIFO and reads from an empty one are dropped
    assign doWrite = write && !full;
    assign doRead = read && !empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            writePtr <= '0;
            readPtr <= '0;
            used <= '0;
            dataValid <= 1'b0;
        end else begin
            if (doWrite) begin
                writePtr <= writePtr + 1'b1;
            end
            if (doRead) begin
                readPtr <= readPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10:   used <= used + 1'b1;
                2'b01:   used <= used - 1'b1;
                default: used <= used;
            endcase
            dataValid <= doRead;
        end
    end

    // Storage and the registered read port
    always_ff @(posedge clk) begin
        if (doWrite) begin
            botMem[writePtr] <= botIn;
            indexMem[writePtr] <= indexIn;
        end
        if (doRead) begin
            dataOut <= botMem[readPtr];
            indexOut <= indexMem[readPtr];
        end
    end

endmodule

// File: design/fifoReadArbiter.sv
module fifoReadArbiter (
    input  logic       clk,
    input  logic       reset,
    input  logic [1:0] request,
    input  logic       empty,
    input  logic       dataValid,
    output logic       fifoRead,
    output logic [1:0] start
);

    // Core 1 wins a tie when set
    logic priorityOne;
    // Core granted last cycle, whose data is on its way back
    logic [1:0] pending;
    logic [1:0] eligible;
    logic [1:0] grant;

    // A core stays idle until its data lands, so mask its request meanwhile
    assign eligible = request & ~pending;

    always_comb begin
        grant = 2'b00;
        if (!empty) begin
            if (eligible == 2'b11) begin
                grant = priorityOne ? 2'b10 : 2'b01;
            end else begin
                grant = eligible;
            end
        end
    end

    assign fifoRead = |grant;

    // FIFO data comes back one cycle after the grant
    assign start = pending & {2{dataValid}};

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 2'b00;
            priorityOne <= 1'b0;
        end else begin
            pending <= grant;
            if (fifoRead) begin
                // The core just served drops to low priority
                priorityOne <= grant[0];
            end
        end
    end

endmodule

// File: design/connectCounter.sv
module connectCounter
    import streamParamsPkg::*, streamTypesPkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  botWordT                top,
    input  botWordT                botIn,
    input  logic [INDEX_WIDTH-1:0] indexIn,
    output logic                   request,
    output logic                   done,
    output countT                  count,
    output logic [INDEX_WIDTH-1:0] indexOut
);

    localparam int SEL_WIDTH = $clog2(CHUNK_COUNT);
    // At most one rise per two bits of a chunk
    localparam int RISE_WIDTH = $clog2(CHUNK_WIDTH / 2 + 1);
    localparam logic [SEL_WIDTH-1:0] LAST_CHUNK = SEL_WIDTH'(CHUNK_COUNT - 1);

    botWordT work;
    logic busy;
    logic [SEL_WIDTH-1:0] chunkSel;
    logic carry;
    countT runCount;
    logic [RISE_WIDTH-1:0] chunkRises;
    logic lastStep;

    // Count the 0 to 1 steps in a chunk, prevBit being the bit just below it
    function automatic logic [RISE_WIDTH-1:0] countRises(
        input logic [CHUNK_WIDTH-1:0] chunk,
        input logic prevBit
    );
        logic [CHUNK_WIDTH-1:0] below;
        logic [CHUNK_WIDTH-1:0] rises;
        logic [RISE_WIDTH-1:0] total;
        below = {chunk[CHUNK_WIDTH-2:0], prevBit};
        rises = chunk & ~below;
        total = '0;
        for (int i = 0; i < CHUNK_WIDTH; i++) begin
            total = total + RISE_WIDTH'(rises[i]);
        end
        return total;
    endfunction

    assign chunkRises = countRises(work.chunks[chunkSel], carry);
    assign lastStep = busy && chunkSel == LAST_CHUNK;
    assign request = !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            chunkSel <= '0;
        end else begin
            done <= lastStep;
            if (start && !busy) begin
                busy <= 1'b1;
                chunkSel <= '0;
            end else if (busy) begin
                chunkSel <= chunkSel + 1'b1;
                if (lastStep) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Scan datapath, one chunk per busy cycle from bit 0 upward
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            work.flat <= botIn.flat & top.flat;
            indexOut <= indexIn;
            carry <= 1'b0;
            runCount <= '0;
        end else if (busy) begin
            carry <= work.chunks[chunkSel][CHUNK_WIDTH-1];
            runCount <= runCount + countT'(chunkRises);
            if (lastStep) begin
                count <= runCount + countT'(chunkRises);
            end
        end
    end

endmodule

// File: design/resultCollector.sv
module resultCollector
    import streamParamsPkg::*, streamTypesPkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   write0,
    input  logic [INDEX_WIDTH-1:0] index0,
    input  countT                  count0,
    input  logic                   write1,
    input  logic [INDEX_WIDTH-1:0] index1,
    input  countT                  count1,
    input  logic [INDEX_WIDTH-1:0] readIndex,
    output countT                  countOut
);

    localparam logic [INDEX_WIDTH-1:0] LAST_INDEX = INDEX_WIDTH'(RING_LENGTH - 1);

    countT countMem [RING_LENGTH];

    // Clearing pass after reset, one entry per cycle
    logic sweepActive;
    logic [INDEX_WIDTH-1:0] sweepIndex;

    always_ff @(posedge clk) begin
        if (reset) begin
            sweepActive <= 1'b1;
            sweepIndex <= '0;
        end else if (sweepActive) begin
            sweepIndex <= sweepIndex + 1'b1;
            if (sweepIndex == LAST_INDEX) begin
                sweepActive <= 1'b0;
            end
        end
    end

    // Sweep runs level with the ring index, well ahead of any core write
    // Core writes come last so they win a clash
    always_ff @(posedge clk) begin
        if (sweepActive) begin
            countMem[sweepIndex] <= '0;
        end
        if (write0) begin
            countMem[index0] <= count0;
        end
        if (write1) begin
            countMem[index1] <= count1;
        end
        countOut <= countMem[readIndex];
    end

endmodule

// File: design/tagDelayMemory.sv
module tagDelayMemory
    import streamParamsPkg::*;
#(
    parameter int EXTRA_WIDTH = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [INDEX_WIDTH-1:0] curIndex,
    input  logic                   valid,
    input  logic [EXTRA_WIDTH-1:0] extraIn,
    output logic                   validOut,
    output logic [EXTRA_WIDTH-1:0] extraOut
);

    localparam int ENTRY_WIDTH = EXTRA_WIDTH + 1;
    localparam int PACK_DEPTH = 1 << PACK_DEPTH_LOG2;
    localparam int ADDR_WIDTH = INDEX_WIDTH - PACK_DEPTH_LOG2;
    localparam int WORD_COUNT = 1 << ADDR_WIDTH;
    // Address, memory and output register stages ahead of the unpack load
    localparam int READ_STAGES = 3;
    localparam logic [PACK_DEPTH_LOG2-1:0] LAST_SLOT = PACK_DEPTH_LOG2'(PACK_DEPTH - 1);
    localparam logic [PACK_DEPTH_LOG2-1:0] READ_SLOT =
        PACK_DEPTH_LOG2'(PACK_DEPTH - 1 - READ_STAGES);
    // Word 0 lands before this point, so the sweep must stop here
    localparam logic [INDEX_WIDTH-1:0] SWEEP_LAST = INDEX_WIDTH'(RING_LENGTH - PACK_DEPTH - 1);

    logic [ADDR_WIDTH-1:0] indexHigh;
    logic [ADDR_WIDTH-1:0] nextHigh;
    logic [PACK_DEPTH_LOG2-1:0] indexLow;

    logic [PACK_DEPTH-1:0][ENTRY_WIDTH-1:0] tagMem [WORD_COUNT];
    logic [PACK_DEPTH-1:0][ENTRY_WIDTH-1:0] packReg;
    logic [PACK_DEPTH-1:0][ENTRY_WIDTH-1:0] readWord;
    logic [PACK_DEPTH-1:0][ENTRY_WIDTH-1:0] readWordQ;
    logic [PACK_DEPTH-1:0][ENTRY_WIDTH-1:0] unpackReg;

    logic pushBlock;
    logic [ADDR_WIDTH-1:0] writeAddr;
    logic [ADDR_WIDTH-1:0] readAddr;
    logic [READ_STAGES-1:0] readPipe;
    logic sweepActive;

    assign indexHigh = curIndex[INDEX_WIDTH-1:PACK_DEPTH_LOG2];
    assign indexLow = curIndex[PACK_DEPTH_LOG2-1:0];
    // Oldest word in the ring, due for replay next
    assign nextHigh = indexHigh + ADDR_WIDTH'(1);

    always_ff @(posedge clk) begin
        if (reset) begin
            packReg <= '0;
            unpackReg <= '0;
            validOut <= 1'b0;
            pushBlock <= 1'b0;
            readPipe <= '0;
            sweepActive <= 1'b1;
        end else begin
            // Slot k ends up holding the entry whose low index bits are k
            packReg <= {valid, extraIn, packReg[PACK_DEPTH-1:1]};
            pushBlock <= indexLow == LAST_SLOT;
            readPipe <= {readPipe[READ_STAGES-2:0], indexLow == READ_SLOT};
            if (curIndex == SWEEP_LAST) begin
                sweepActive <= 1'b0;
            end
            if (readPipe[READ_STAGES-1]) begin
                unpackReg <= {{ENTRY_WIDTH{1'b0}}, readWordQ[PACK_DEPTH-1:1]};
                validOut <= readWordQ[0][ENTRY_WIDTH-1];
            end else begin
                unpackReg <= {{ENTRY_WIDTH{1'b0}}, unpackReg[PACK_DEPTH-1:1]};
                validOut <= unpackReg[0][ENTRY_WIDTH-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        writeAddr <= indexHigh;
        if (pushBlock) begin
            tagMem[writeAddr] <= packReg;
        end else if (sweepActive) begin
            tagMem[nextHigh] <= '0;
        end
        if (indexLow == READ_SLOT) begin
            readAddr <= nextHigh;
        end
        if (readPipe[0]) begin
            readWord <= tagMem[readAddr];
        end
        if (readPipe[1]) begin
            readWordQ <= readWord;
        end
        // Tag payload follows the same replay as the valid flag
        if (readPipe[READ_STAGES-1]) begin
            extraOut <= readWordQ[0][EXTRA_WIDTH-1:0];
        end else begin
            extraOut <= unpackReg[0][EXTRA_WIDTH-1:0];
        end
    end

endmodule

// File: design/streamingCountTop.sv
module streamingCountTop
    import streamParamsPkg::*, streamTypesPkg::*;
#(
    parameter int EXTRA_WIDTH = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [BOT_WIDTH-1:0]   top,
    input  logic                   botValid,
    input  botWordT                bot,
    input  logic [EXTRA_WIDTH-1:0] extraIn,
    output logic                   slowDown,
    output logic                   resultValid,
    output countT                  connectCount,
    output logic [EXTRA_WIDTH-1:0] extraOut
);

    logic [INDEX_WIDTH-1:0] curIndex;
    logic [INDEX_WIDTH-1:0] readIndex;
    botWordT topMask;

    logic [FIFO_DEPTH_LOG2:0] fifoUsed;
    logic fifoEmpty;
    logic fifoRead;
    logic fifoDataValid;
    botWordT fifoData;
    logic [INDEX_WIDTH-1:0] fifoIndex;

    logic [1:0] coreRequest;
    logic [1:0] coreStart;
    logic [1:0] coreDone;
    countT coreCount [2];
    logic [INDEX_WIDTH-1:0] coreIndex [2];

    // Free-running ring index, every word is stamped with it on entry
    always_ff @(posedge clk) begin
        if (reset) begin
            curIndex <= '0;
        end else begin
            curIndex <= curIndex + 1'b1;
        end
    end

    // Collector read is registered, so look one entry ahead
    assign readIndex = curIndex + INDEX_WIDTH'(1);
    assign slowDown = fifoUsed >= (FIFO_DEPTH_LOG2 + 1)'(SLOW_THRESHOLD);
    assign topMask.flat = top;

    inputFifo fifo (
        .clk(clk),
        .reset(reset),
        .write(botValid),
        .botIn(bot),
        .indexIn(curIndex),
        .read(fifoRead),
        .dataOut(fifoData),
        .indexOut(fifoIndex),
        .dataValid(fifoDataValid),
        .used(fifoUsed),
        .empty(fifoEmpty)
    );

    fifoReadArbiter arbiter (
        .clk(clk),
        .reset(reset),
        .request(coreRequest),
        .empty(fifoEmpty),
        .dataValid(fifoDataValid),
        .fifoRead(fifoRead),
        .start(coreStart)
    );

    for (genvar coreNum = 0; coreNum < 2; coreNum++) begin : coreGen
        connectCounter core (
            .clk(clk),
            .reset(reset),
            .start(coreStart[coreNum]),
            .top(topMask),
            .botIn(fifoData),
            .indexIn(fifoIndex),
            .request(coreRequest[coreNum]),
            .done(coreDone[coreNum]),
            .count(coreCount[coreNum]),
            .indexOut(coreIndex[coreNum])
        );
    end

    resultCollector collector (
        .clk(clk),
        .reset(reset),
        .write0(coreDone[0]),
        .index0(coreIndex[0]),
        .count0(coreCount[0]),
        .write1(coreDone[1]),
        .index1(coreIndex[1]),
        .count1(coreCount[1]),
        .readIndex(readIndex),
        .countOut(connectCount)
    );

    tagDelayMemory #(
        .EXTRA_WIDTH(EXTRA_WIDTH)
    ) tagDelay (
        .clk(clk),
        .reset(reset),
        .curIndex(curIndex),
        .valid(botValid),
        .extraIn(extraIn),
        .validOut(resultValid),
        .extraOut(extraOut)
    );

endmodule

// File: testbench/streamingCount_chk.sv
module streamingCountChk
    import streamParamsPkg::*, streamTypesPkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  botValid,
    input logic  slowDown,
    input logic  resultValid,
    input countT connectCount
);
    timeunit 1ns;
    timeprecision 100ps;

    // Cycles since reset, saturating
    logic [7:0] sinceReset;

    always_ff @(posedge clk) begin
        if (reset) begin
            sinceReset <= '0;
        end else if (sinceReset != 8'hFF) begin
            sinceReset <= sinceReset + 8'd1;
        end
    end

    // Nothing can leave before one trip around the ring
    noEarlyResult: assert property (
        @(posedge clk) disable iff (reset)
        sinceReset < 8'(RING_LENGTH) |-> !resultValid
    ) else $error("resultValid high within the first ring after reset");

    // Source must hold off while the FIFO is nearly full
    slowDownHonored: assert property (
        @(posedge clk) disable iff (reset)
        slowDown |-> !botValid
    ) else $error("botValid high while slowDown is high");

    // Alternating bits give the largest count
    countInRange: assert property (
        @(posedge clk) disable iff (reset)
        resultValid |-> connectCount <= countT'(RING_LENGTH)
    ) else $error("connectCount above the largest possible run count");

endmodule

// File: testbench/streamingCountTb.sv
module streamingCountTb
    import streamParamsPkg::*, streamTypesPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int EXTRA_WIDTH = 4;
    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 4;
    localparam int START_IDLE = 6;
    localparam int DRAIN_CYCLES = 70;
    localparam int RANDOM_WORDS = 200;
    localparam int TABLE_LEN = 16;

    // All ones, upper byte of every halfword, low 64 bits
    localparam logic [BOT_WIDTH-1:0] MASKS [3] = '{
        128'hFFFF_FFFF_FFFF_FFFF_FFFF_FFFF_FFFF_FFFF,
        128'hFF00_FF00_FF00_FF00_FF00_FF00_FF00_FF00,
        128'h0000_0000_0000_0000_FFFF_FFFF_FFFF_FFFF
    };

    // Directed words with their mask, tag, trailing gap and run count
    localparam logic [BOT_WIDTH-1:0] TABLE_BOT [TABLE_LEN] = '{
        128'h0000_0000_0000_0000_0000_0000_0000_0000,
        128'hFFFF_FFFF_FFFF_FFFF_FFFF_FFFF_FFFF_FFFF,
        128'h5555_5555_5555_5555_5555_5555_5555_5555,
        128'hAAAA_AAAA_AAAA_AAAA_AAAA_AAAA_AAAA_AAAA,
        128'h0000_0000_0000_0000_0000_0000_0001_8000,
        128'h8000_0000_0000_0000_0000_0000_0000_0001,
        128'h0000_0000_0000_FFFF_FFFF_0000_0000_0000,
        128'hF0F0_F0F0_F0F0_F0F0_F0F0_F0F0_F0F0_F0F0,
        128'h7FFF_0000_FFFE_0000_1234_0000_8001_0000,
        128'hFFFF_FFFF_FFFF_FFFF_FFFF_FFFF_FFFF_FFFF,
        128'h5555_5555_5555_5555_5555_5555_5555_5555,
        128'h0000_0000_0000_0000_0000_0000_0001_8000,
        128'h0F0F_0F0F_0F0F_0F0F_0F0F_0F0F_0F0F_0F0F,
        128'hFFFF_FFFF_FFFF_FFFF_FFFF_FFFF_FFFF_FFFF,
        128'h8000_0000_0000_0000_0000_0000_0000_0001,
        128'h5555_5555_5555_5555_5555_5555_5555_5555
    };
    localparam int TABLE_MASK [TABLE_LEN] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 1, 2, 2, 2};
    localparam logic [EXTRA_WIDTH-1:0] TABLE_TAG [TABLE_LEN] = '{
        4'h3, 4'hA, 4'h5, 4'hC, 4'h0, 4'hF, 4'h7, 4'h9,
        4'h1, 4'hE, 4'h6, 4'hB, 4'h2, 4'hD, 4'h8, 4'h4
    };
    localparam int TABLE_GAP [TABLE_LEN] = '{2, 0, 0, 0, 3, 0, 0, 0, 1, 0, 0, 0, 2, 0, 0, 4};
    localparam int TABLE_COUNT [TABLE_LEN] = '{
        0, 1, 64, 64, 1, 2, 1, 16, 8, 8, 32, 1, 8, 1, 1, 32
    };

    logic clk;
    logic reset;
    logic [BOT_WIDTH-1:0] top;
    logic botValid;
    botWordT bot;
    logic [EXTRA_WIDTH-1:0] extraIn;
    logic slowDown;
    logic resultValid;
    countT connectCount;
    logic [EXTRA_WIDTH-1:0] extraOut;

    int seed = 73;
    int cycle;
    bit sawSlowDown;
    // Words in flight with the oldest first
    int sendCycle [$];
    countT expCount [$];
    logic [EXTRA_WIDTH-1:0] expTag [$];

    streamingCountTop #(
        .EXTRA_WIDTH(EXTRA_WIDTH)
    ) dut (
        .clk(clk),
        .reset(reset),
        .top(top),
        .botValid(botValid),
        .bot(bot),
        .extraIn(extraIn),
        .slowDown(slowDown),
        .resultValid(resultValid),
        .connectCount(connectCount),
        .extraOut(extraOut)
    );

    bind streamingCountTop streamingCountChk chk (
        .clk(clk),
        .reset(reset),
        .botValid(botValid),
        .slowDown(slowDown),
        .resultValid(resultValid),
        .connectCount(connectCount)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "Run stopped at cycle %0d", cycle);
    endtask

    task automatic checkCount(input countT actual, input countT expected);
        if (actual !== expected) begin
            abortRun($sformatf("FAILED connectCount: got %h, expected %h at cycle %0d",
                actual, expected, cycle));
        end
    endtask

    task automatic checkExtra(input logic [EXTRA_WIDTH-1:0] actual,
                              input logic [EXTRA_WIDTH-1:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("FAILED extraOut: got %h, expected %h at cycle %0d",
                actual, expected, cycle));
        end
    endtask

    task automatic checkValid(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            abortRun($sformatf("FAILED %s: got %h, expected %h at cycle %0d",
                name, actual, expected, cycle));
        end
    endtask

    // Count runs of ones from bit 0 upward by their 0 to 1 steps
    function automatic countT referenceRuns(input logic [BOT_WIDTH-1:0] word);
        countT runs;
        logic prev;
        runs = '0;
        prev = 1'b0;
        for (int i = 0; i < BOT_WIDTH; i++) begin
            if (word[i] && !prev) begin
                runs = runs + countT'(1);
            end
            prev = word[i];
        end
        return runs;
    endfunction

    function automatic int plannedCycles();
        int total;
        total = RESET_CYCLES + START_IDLE + 2 * DRAIN_CYCLES;
        for (int i = 0; i < TABLE_LEN; i++) begin
            total += 1 + TABLE_GAP[i];
            if (i > 0 && TABLE_MASK[i] != TABLE_MASK[i - 1]) begin
                total += DRAIN_CYCLES;
            end
        end
        total += RANDOM_WORDS * 10 + 200;
        return total;
    endfunction

    // A word sent in cycle n is due in cycle n + RING_LENGTH
    task automatic checkOutputs();
        if (sendCycle.size() > 0 && sendCycle[0] == cycle - RING_LENGTH) begin
            checkValid("resultValid", resultValid, 1'b1);
            checkCount(connectCount, expCount.pop_front());
            checkExtra(extraOut, expTag.pop_front());
            sendCycle.delete(0);
        end else begin
            checkValid("resultValid", resultValid, 1'b0);
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
        cycle++;
        checkOutputs();
    endtask

    task automatic idleCycle();
        botValid = 1'b0;
        nextCycle();
    endtask

    task automatic sendWord(input logic [BOT_WIDTH-1:0] value,
                            input logic [EXTRA_WIDTH-1:0] tag, input countT expected);
        while (slowDown) begin
            sawSlowDown = 1'b1;
            idleCycle();
        end
        botValid = 1'b1;
        bot.flat = value;
        extraIn = tag;
        sendCycle.push_back(cycle);
        expCount.push_back(expected);
        expTag.push_back(tag);
        nextCycle();
        botValid = 1'b0;
    endtask

    // Let every word in flight come out before the mask moves
    task automatic changeMask(input logic [BOT_WIDTH-1:0] mask);
        repeat (DRAIN_CYCLES) idleCycle();
        top = mask;
    endtask

    task automatic randomWord(output logic [BOT_WIDTH-1:0] value);
        for (int i = 0; i < BOT_WIDTH / 32; i++) begin
            value[i * 32 +: 32] = $random(seed);
        end
    endtask

    initial begin
        int limit;
        limit = plannedCycles();
        #(limit * CLK_PERIOD);
        abortRun($sformatf("Watchdog expired: no verdict after %0d cycles", limit));
    end

    initial begin
        logic [BOT_WIDTH-1:0] value;
        logic [BOT_WIDTH-1:0] mask;
        logic [EXTRA_WIDTH-1:0] tag;
        reset = 1'b1;
        botValid = 1'b0;
        bot.flat = '0;
        extraIn = '0;
        top = MASKS[TABLE_MASK[0]];
        cycle = 0;
        sawSlowDown = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        checkValid("slowDown", slowDown, 1'b0);
        checkValid("resultValid", resultValid, 1'b0);
        // Quiet start where no stale result may show
        repeat (START_IDLE) idleCycle();

        for (int i = 0; i < TABLE_LEN; i++) begin
            if (i > 0 && TABLE_MASK[i] != TABLE_MASK[i - 1]) begin
                changeMask(MASKS[TABLE_MASK[i]]);
            end
            sendWord(TABLE_BOT[i], TABLE_TAG[i], countT'(TABLE_COUNT[i]));
            repeat (TABLE_GAP[i]) idleCycle();
        end

        // Random stream as fast as slowDown allows
        randomWord(mask);
        changeMask(mask);
        for (int n = 0; n < RANDOM_WORDS; n++) begin
            randomWord(value);
            tag = EXTRA_WIDTH'($random(seed));
            sendWord(value, tag, referenceRuns(value & mask));
        end
        repeat (DRAIN_CYCLES) idleCycle();

        if (sendCycle.size() == 0 && sawSlowDown) begin
            $display("** PASS **");
            $finish;
        end else if (!sawSlowDown) begin
            abortRun("slowDown never rose during the random stream");
        end else begin
            abortRun($sformatf("%0d results never appeared", sendCycle.size()));
        end
    end

endmodule

// File: filelist.f
design/streamParamsPkg.sv
design/streamTypesPkg.sv
design/inputFifo.sv
design/fifoReadArbiter.sv
design/connectCounter.sv
design/resultCollector.sv
design/tagDelayMemory.sv
design/streamingCountTop.sv
testbench/streamingCount_chk.sv
testbench/streamingCountTb.sv

// File: run.sh
#!/bin/sh
# Build and run the streaming counter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module streamingCountTb -f filelist.f -o streamingCountSim

./obj_dir/streamingCountSim
